// File: rs_pkg.sv
package rs_pkg;

	// reorder-buffer tag width
	localparam int tag_w = 4;
	localparam int n_entry = 2;

	typedef logic [tag_w-1:0] rob_tag_t;
	typedef logic [31:0] word_t;

	// operand slot or one CDB broadcast
	typedef struct packed {
		logic valid;
		rob_tag_t tag;
		word_t data;
	} cdb_t;

	typedef enum logic {
		op_div,
		op_sqrt
	} ds_op_t;

	typedef struct packed {
		logic valid;
		rob_tag_t tag;
		ds_op_t op;
		cdb_t [1:0] opd;
	} rs_entry_t;

	typedef struct packed {
		rob_tag_t tag;
		ds_op_t op;
		cdb_t [1:0] opd;
	} issue_t;

	localparam rs_entry_t rs_entry_empty = '0;

endpackage

// File: unit_pkg.sv
package unit_pkg;

	// one result bit per cycle
	localparam int div_iters = 32;
	localparam int sqrt_iters = 16;

	localparam int cnt_w = 5;

	typedef logic [cnt_w-1:0] iter_cnt_t;

	typedef enum logic [1:0] {
		st_idle,
		st_busy,
		st_done
	} ds_state_t;

endpackage

// File: div_sqrt_rs.sv
`timescale 1ns/1ps

module div_sqrt_rs (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input rs_pkg::issue_t issue,
	input rs_pkg::cdb_t cdb_in,
	input logic unit_ready,
	output logic issue_ready,
	output logic dispatch_valid,
	output rs_pkg::rs_entry_t dispatch
);
	import rs_pkg::*;

	// packed from index 0, entry 0 is the oldest
	rs_entry_t entry [n_entry];
	rs_entry_t entry_upd [n_entry];
	rs_entry_t entry_new;
	cdb_t issue_opd1;
	logic [n_entry-1:0] entry_rdy;
	logic sel;
	logic do_dispatch;
	logic accept;

	// capture broadcast data for a waiting operand
	function automatic cdb_t wake(cdb_t opd, cdb_t bus);
		cdb_t res;
		res = opd;
		if (!opd.valid && bus.valid && bus.tag == opd.tag) begin
			res.valid = 1'b1;
			res.data = bus.data;
		end
		return res;
	endfunction

	// square root has no second operand
	always_comb begin
		issue_opd1 = issue.opd[1];
		if (issue.op == op_sqrt) begin
			issue_opd1.valid = 1'b1;
		end
	end

	always_comb begin
		entry_new.valid = accept;
		entry_new.tag = issue.tag;
		entry_new.op = issue.op;
		entry_new.opd[0] = wake(issue.opd[0], cdb_in);
		entry_new.opd[1] = wake(issue_opd1, cdb_in);
	end

	for (genvar i = 0; i < n_entry; i++) begin : g_entry
		always_comb begin
			entry_upd[i] = entry[i];
			entry_upd[i].opd[0] = wake(entry[i].opd[0], cdb_in);
			entry_upd[i].opd[1] = wake(entry[i].opd[1], cdb_in);
		end

		assign entry_rdy[i] = entry[i].valid && entry[i].opd[0].valid &&
			entry[i].opd[1].valid;
	end

	// oldest ready entry wins
	assign sel = !entry_rdy[0];
	assign dispatch_valid = |entry_rdy;
	assign dispatch = entry[sel];
	assign do_dispatch = dispatch_valid && unit_ready;

	// a full station still accepts when one entry leaves this cycle
	assign issue_ready = do_dispatch || !entry[n_entry-1].valid;
	assign accept = issue_valid && issue_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			entry[0] <= rs_entry_empty;
			entry[1] <= rs_entry_empty;
		end else if (do_dispatch) begin
			if (sel == 1'b0) begin
				entry[0] <= entry[1].valid ? entry_upd[1] : entry_new;
			end else begin
				entry[0] <= entry_upd[0];
			end
			entry[1] <= entry[1].valid ? entry_new : rs_entry_empty;
		end else begin
			entry[0] <= entry[0].valid ? entry_upd[0] : entry_new;
			if (entry[1].valid) begin
				entry[1] <= entry_upd[1];
			end else if (entry[0].valid) begin
				entry[1] <= entry_new;
			end else begin
				entry[1] <= rs_entry_empty;
			end
		end
	end

endmodule

// File: div_sqrt_ctrl.sv
`timescale 1ns/1ps

module div_sqrt_ctrl (
	input logic clk,
	input logic reset,
	input logic dispatch_valid,
	input logic last_iter,
	input logic cdb_grant,
	output logic unit_ready,
	output logic start,
	output logic step,
	output logic cdb_req
);
	import unit_pkg::*;

	ds_state_t state;
	ds_state_t state_nxt;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (dispatch_valid) begin
					state_nxt = st_busy;
				end
			end
			st_busy: begin
				if (last_iter) begin
					state_nxt = st_done;
				end
			end
			st_done: begin
				// result held until the bus takes it
				if (cdb_grant) begin
					state_nxt = st_idle;
				end
			end
			default: begin
				state_nxt = st_idle;
			end
		endcase
	end

	assign unit_ready = state == st_idle;

	// dispatch edge
	assign start = unit_ready && dispatch_valid;

	assign step = state == st_busy;
	assign cdb_req = state == st_done;

endmodule

// File: iter_counter.sv
`timescale 1ns/1ps

module iter_counter (
	input logic clk,
	input logic reset,
	input logic start,
	input rs_pkg::ds_op_t op,
	input logic step,
	output logic last_iter
);
	import rs_pkg::*;
	import unit_pkg::*;

	iter_cnt_t cnt;
	iter_cnt_t load_val;

	assign load_val = (op == op_sqrt) ? iter_cnt_t'(sqrt_iters - 1) :
		iter_cnt_t'(div_iters - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
		end else if (start) begin
			cnt <= load_val;
		end else if (step && cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign last_iter = step && cnt == '0;

endmodule

// File: div_sqrt_datapath.sv
`timescale 1ns/1ps

module div_sqrt_datapath (
	input logic clk,
	input logic reset,
	input logic start,
	input logic step,
	input rs_pkg::ds_op_t op,
	input rs_pkg::word_t opd_a,
	input rs_pkg::word_t opd_b,
	input rs_pkg::rob_tag_t tag_in,
	output rs_pkg::word_t result,
	output rs_pkg::rob_tag_t result_tag
);
	import rs_pkg::*;

	ds_op_t op_q;
	// dividend or radicand, consumed from the top
	word_t src_q;
	word_t divisor_q;
	rob_tag_t tag_q;
	word_t res_q;

	// wide enough for a shifted divide remainder
	logic [33:0] rem_q;
	logic [33:0] shifted;
	logic [33:0] subtrahend;
	logic [33:0] diff;
	logic fits;

	always_comb begin
		if (op_q == op_div) begin
			shifted = {rem_q[32:0], src_q[31]};
			subtrahend = {2'b00, divisor_q};
		end else begin
			// two radicand bits per step, trial value is 4*root + 1
			shifted = {rem_q[31:0], src_q[31:30]};
			subtrahend = {16'b0, res_q[15:0], 2'b01};
		end
		diff = shifted - subtrahend;
		fits = shifted >= subtrahend;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			op_q <= op_div;
			res_q <= '0;
		end else if (start) begin
			op_q <= op;
			res_q <= '0;
		end else if (step) begin
			res_q <= {res_q[30:0], fits};
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			src_q <= opd_a;
			divisor_q <= opd_b;
			tag_q <= tag_in;
			rem_q <= '0;
		end else if (step) begin
			rem_q <= fits ? diff : shifted;
			if (op_q == op_div) begin
				src_q <= {src_q[30:0], 1'b0};
			end else begin
				src_q <= {src_q[29:0], 2'b00};
			end
		end
	end

	assign result = res_q;
	assign result_tag = tag_q;

endmodule

// File: div_sqrt_unit.sv
`timescale 1ns/1ps

module div_sqrt_unit (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input rs_pkg::issue_t issue,
	output logic issue_ready,
	input rs_pkg::cdb_t cdb_in,
	output logic cdb_req,
	output rs_pkg::rob_tag_t result_tag,
	output rs_pkg::word_t result,
	input logic cdb_grant
);
	import rs_pkg::*;

	logic dispatch_valid;
	rs_entry_t dispatch;
	logic unit_ready;
	logic start;
	logic step;
	logic last_iter;

	div_sqrt_rs rs_i (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue(issue),
		.cdb_in(cdb_in),
		.unit_ready(unit_ready),
		.issue_ready(issue_ready),
		.dispatch_valid(dispatch_valid),
		.dispatch(dispatch)
	);

	div_sqrt_ctrl ctrl_i (
		.clk(clk),
		.reset(reset),
		.dispatch_valid(dispatch_valid),
		.last_iter(last_iter),
		.cdb_grant(cdb_grant),
		.unit_ready(unit_ready),
		.start(start),
		.step(step),
		.cdb_req(cdb_req)
	);

	iter_counter cnt_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.op(dispatch.op),
		.step(step),
		.last_iter(last_iter)
	);

	div_sqrt_datapath dp_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.step(step),
		.op(dispatch.op),
		.opd_a(dispatch.opd[0].data),
		.opd_b(dispatch.opd[1].data),
		.tag_in(dispatch.tag),
		.result(result),
		.result_tag(result_tag)
	);

endmodule

// File: tb_div_sqrt.sv
`timescale 1ns/1ps

module tb_div_sqrt;
	import rs_pkg::*;
	import unit_pkg::*;

	logic clk;
	logic reset;
	logic issue_valid;
	issue_t issue;
	logic issue_ready;
	cdb_t cdb_in;
	logic cdb_req;
	rob_tag_t result_tag;
	word_t result;
	logic cdb_grant;

	integer seed = 32'h5f81;
	int limit = 20 * (div_iters + 2);
	int cyc = 0;
	int n_issued = 0;
	int n_done = 0;
	int grant_max = 0;
	bit hold_grant = 1'b0;
	string test_name = "reset";

	// scoreboard indexed by result tag
	word_t expected [16];
	bit outstanding [16];
	rob_tag_t done_q [$];

	// other CDB producers
	// slot is the low three bits of the producer tag
	bit pend_on [8];
	int pend_due [8];
	word_t pend_data [8];

	div_sqrt_unit dut_i (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue(issue),
		.issue_ready(issue_ready),
		.cdb_in(cdb_in),
		.cdb_req(cdb_req),
		.result_tag(result_tag),
		.result(result),
		.cdb_grant(cdb_grant)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic word_t ref_result(input ds_op_t op, input word_t a, input word_t b);
		logic [63:0] root;
		logic [63:0] trial;
		if (op == op_div) begin
			return (b == 0) ? '1 : a / b;
		end
		// set root bits from the top while the square still fits
		root = '0;
		for (int i = 15; i >= 0; i--) begin
			trial = root | (64'd1 << i);
			if (trial * trial <= {32'b0, a}) begin
				root = trial;
			end
		end
		return root[31:0];
	endfunction

	task automatic stop_with_error(input string why);
		$display("ERROR: %s", why);
		$display("RESULT: FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic check(input string name, input word_t exp_val, input word_t act_val);
		if (exp_val !== act_val) begin
			$display("FAIL %s expected %h actual %h", name, exp_val, act_val);
			$display("RESULT: FAIL");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#10;
		end
	endtask

	task automatic schedule_broadcast(input rob_tag_t ptag, input word_t data, input int dly);
		pend_on[ptag[2:0]] = 1'b1;
		pend_data[ptag[2:0]] = data;
		pend_due[ptag[2:0]] = cyc + dly;
	endtask

	// a negative d0 broadcasts operand 0 in the issue cycle itself
	task automatic issue_instr(input rob_tag_t tag, input ds_op_t op, input word_t a,
			input word_t b, input bit v0, input bit v1, input int d0, input int d1);
		issue_t ins;
		rob_tag_t pt0;
		rob_tag_t pt1;
		int cnt;
		pt0 = {1'b1, tag[1:0], 1'b0};
		pt1 = {1'b1, tag[1:0], 1'b1};
		expected[tag] = ref_result(op, a, b);
		outstanding[tag] = 1'b1;
		n_issued++;
		if (!v0 && d0 < 0) begin
			schedule_broadcast(pt0, a, 1);
			idle_cycles(1);
		end
		ins.tag = tag;
		ins.op = op;
		ins.opd[0].valid = v0;
		ins.opd[0].tag = v0 ? '0 : pt0;
		ins.opd[0].data = v0 ? a : ~a;
		ins.opd[1].valid = v1;
		ins.opd[1].tag = v1 ? '0 : pt1;
		ins.opd[1].data = v1 ? b : ~b;
		issue = ins;
		issue_valid = 1'b1;
		cnt = 0;
		@(negedge clk);
		while (!issue_ready) begin
			cnt++;
			if (cnt > limit) begin
				stop_with_error("issue handshake timed out");
			end
			@(posedge clk);
			#10;
			@(negedge clk);
		end
		@(posedge clk);
		#10;
		issue_valid = 1'b0;
		if (!v0 && d0 >= 0) begin
			schedule_broadcast(pt0, a, d0 + 1);
		end
		if (!v1) begin
			schedule_broadcast(pt1, b, d1 + 1);
		end
	endtask

	task automatic wait_tag_done(input rob_tag_t tag);
		int cnt;
		cnt = 0;
		while (outstanding[tag]) begin
			idle_cycles(1);
			cnt++;
			if (cnt > limit) begin
				stop_with_error("timed out waiting for a tag to complete");
			end
		end
	endtask

	task automatic wait_all_done();
		int cnt;
		cnt = 0;
		while (n_done != n_issued) begin
			idle_cycles(1);
			cnt++;
			if (cnt > limit) begin
				stop_with_error("timed out waiting for all results");
			end
		end
	endtask

	task automatic wait_for_req();
		int cnt;
		cnt = 0;
		while (!cdb_req) begin
			idle_cycles(1);
			cnt++;
			if (cnt > limit) begin
				stop_with_error("timed out waiting for cdb_req");
			end
		end
	endtask

	initial begin : producer
		cdb_in = '0;
		forever begin
			@(posedge clk);
			#10;
			cdb_in = '0;
			for (int i = 0; i < 8; i++) begin
				if (pend_on[i] && pend_due[i] <= cyc && !cdb_in.valid) begin
					cdb_in.valid = 1'b1;
					cdb_in.tag = rob_tag_t'(8 + i);
					cdb_in.data = pend_data[i];
					pend_on[i] = 1'b0;
				end
			end
		end
	end

	// plays the CDB arbiter
	initial begin : grant_driver
		int wait_n;
		wait_n = 0;
		cdb_grant = 1'b0;
		forever begin
			@(posedge clk);
			#10;
			cdb_grant = 1'b0;
			if (cdb_req && !hold_grant) begin
				if (wait_n == 0) begin
					cdb_grant = 1'b1;
					@(negedge clk);
					wait_n = $unsigned($random(seed)) % (grant_max + 1);
				end else begin
					wait_n--;
				end
			end
		end
	end

	initial begin : monitor
		logic prev_req;
		logic prev_grant;
		rob_tag_t prev_tag;
		word_t prev_result;
		prev_req = 1'b0;
		prev_grant = 1'b0;
		prev_tag = '0;
		prev_result = '0;
		forever begin
			@(negedge clk);
			if (!reset) begin
				if (prev_req && !prev_grant) begin
					if (!cdb_req) begin
						stop_with_error("cdb_req dropped before a grant");
					end
					check({test_name, " held tag"}, 32'(prev_tag), 32'(result_tag));
					check({test_name, " held result"}, prev_result, result);
				end
				if (cdb_req && cdb_grant) begin
					if (!outstanding[result_tag]) begin
						stop_with_error("result for a tag that is not outstanding");
					end
					check(test_name, expected[result_tag], result);
					outstanding[result_tag] = 1'b0;
					done_q.push_back(result_tag);
					n_done++;
				end
			end
			prev_req = cdb_req;
			prev_grant = cdb_grant;
			prev_tag = result_tag;
			prev_result = result;
		end
	end

	initial begin : main
		rob_tag_t tag;
		ds_op_t op;
		word_t a;
		word_t b;
		bit v0;
		bit v1;
		int base;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue = '0;
		repeat (16) @(posedge clk);
		#10;
		reset = 1'b0;
		check("reset issue_ready", 32'd1, 32'(issue_ready));
		check("reset cdb_req", 32'd0, 32'(cdb_req));

		test_name = "directed";
		issue_instr(4'd0, op_div, 32'd100, 32'd7, 1'b1, 1'b1, 0, 0);
		issue_instr(4'd1, op_div, 32'h1234, 32'd0, 1'b1, 1'b1, 0, 0);
		issue_instr(4'd2, op_div, 32'd3, 32'd10, 1'b1, 1'b1, 0, 0);
		issue_instr(4'd3, op_div, 32'hffffffff, 32'd1, 1'b1, 1'b1, 0, 0);
		issue_instr(4'd4, op_sqrt, 32'd0, 32'd0, 1'b1, 1'b1, 0, 0);
		issue_instr(4'd5, op_sqrt, 32'd1, 32'd0, 1'b1, 1'b1, 0, 0);
		issue_instr(4'd6, op_sqrt, 32'd144, 32'd0, 1'b1, 1'b1, 0, 0);
		issue_instr(4'd7, op_sqrt, 32'hffffffff, 32'd0, 1'b1, 1'b1, 0, 0);
		wait_all_done();

		test_name = "wakeup";
		issue_instr(4'd6, op_sqrt, 32'd99999, 32'd0, 1'b0, 1'b1, -1, 0);
		issue_instr(4'd4, op_div, 32'd1000, 32'd9, 1'b0, 1'b1, 2, 0);
		issue_instr(4'd5, op_div, 32'd77777, 32'd13, 1'b1, 1'b0, 0, 5);
		wait_all_done();
		issue_instr(4'd4, op_div, 32'h80000000, 32'd3, 1'b0, 1'b0, 3, 45);
		idle_cycles(40);
		check("wakeup early result", 32'd1, 32'(outstanding[4]));
		wait_all_done();

		test_name = "oldest ready";
		base = done_q.size();
		issue_instr(4'd1, op_div, 32'd5000, 32'd7, 1'b0, 1'b1, 60, 0);
		issue_instr(4'd2, op_sqrt, 32'd65536, 32'd0, 1'b1, 1'b1, 0, 0);
		wait_all_done();
		check("first done tag", 32'd2, 32'(done_q[base]));
		check("second done tag", 32'd1, 32'(done_q[base + 1]));

		test_name = "backpressure";
		hold_grant = 1'b1;
		issue_instr(4'd0, op_div, 32'd123456789, 32'd1000, 1'b1, 1'b1, 0, 0);
		wait_for_req();
		issue_instr(4'd1, op_sqrt, 32'd1000000, 32'd0, 1'b1, 1'b1, 0, 0);
		issue_instr(4'd2, op_div, 32'd999, 32'd3, 1'b1, 1'b1, 0, 0);
		@(negedge clk);
		check("full issue_ready", 32'd0, 32'(issue_ready));
		idle_cycles(50);
		hold_grant = 1'b0;
		wait_all_done();

		test_name = "random";
		grant_max = 4;
		for (int n = 0; n < 200; n++) begin
			tag = rob_tag_t'(n % 4);
			wait_tag_done(tag);
			op = ($random(seed) & 1) ? op_sqrt : op_div;
			a = $random(seed);
			b = $unsigned($random(seed)) >> ($unsigned($random(seed)) % 32);
			v0 = $random(seed) & 1;
			v1 = $random(seed) & 1;
			issue_instr(tag, op, a, b, v0, v1, $unsigned($random(seed)) % 8,
				$unsigned($random(seed)) % 8);
			idle_cycles($unsigned($random(seed)) % 4);
		end
		wait_all_done();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: compile.f
rs_pkg.sv
unit_pkg.sv
div_sqrt_rs.sv
div_sqrt_ctrl.sv
iter_counter.sv
div_sqrt_datapath.sv
div_sqrt_unit.sv
tb_div_sqrt.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_div_sqrt
RTL_TOP ?= div_sqrt_unit
FLIST ?= compile.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
